/* hdl/robotPkg.sv */
package robotPkg;

    localparam int GridRows = 10;
    localparam int GridCols = 20;

    typedef logic [3:0] rowT;
    typedef logic [4:0] colT;
    typedef logic [3:0] lifeT;     // Remove steps left on the debris ahead

    typedef enum logic [3:0]
    {
        free         = 4'd0,
        wall         = 4'd1,
        blackCell    = 4'd2,
        debrisLight  = 4'd3,
        debrisMedium = 4'd4,
        debrisHeavy  = 4'd5
    } cellT;

    // Counter-clockwise order, so a left turn is the next code
    typedef enum logic [1:0]
    {
        north = 2'd0,
        west  = 2'd1,
        south = 2'd2,
        east  = 2'd3
    } headingT;

    function automatic lifeT debrisLife(input cellT c);
        case (c)
            debrisLight:  debrisLife = 4'd3;
            debrisMedium: debrisLife = 4'd6;
            debrisHeavy:  debrisLife = 4'd9;
            default:      debrisLife = 4'd0;
        endcase
    endfunction

    function automatic logic isBlocking(input cellT c);
        isBlocking = (c == wall) || (debrisLife(c) != 4'd0);
    endfunction

    function automatic headingT turnLeft(input headingT h);
        turnLeft = headingT'(h + 2'd1);     // Wraps east back to north
    endfunction

    // True when the cell ahead in direction h lies off the grid
    function automatic logic offGrid(input rowT r, input colT c, input headingT h);
        case (h)
            north:   offGrid = (r == 4'd0);
            south:   offGrid = (r == rowT'(GridRows - 1));
            east:    offGrid = (c == colT'(GridCols - 1));
            default: offGrid = (c == 5'd0);
        endcase
    endfunction

    function automatic rowT nextRow(input rowT r, input headingT h);
        case (h)
            north:   nextRow = r - 4'd1;
            south:   nextRow = r + 4'd1;
            default: nextRow = r;
        endcase
    endfunction

    function automatic colT nextCol(input colT c, input headingT h);
        case (h)
            east:    nextCol = c + 5'd1;
            west:    nextCol = c - 5'd1;
            default: nextCol = c;
        endcase
    endfunction

endpackage

/* hdl/frameTimer.sv */
`timescale 1ns/1ps

module frameTimer
#(
    parameter int FramesPerSense = 5,
    parameter int FramesPerStep  = 9
)
(
    input  logic Clock50,
    input  logic reset,
    input  logic vSync,
    output logic senseTick,
    output logic stepTick
);

    localparam int SenseW = $clog2(FramesPerSense + 1);
    localparam int StepW  = $clog2(FramesPerStep + 1);

    logic vSyncMeta;
    logic vSyncSync;
    logic vSyncLast;
    logic frameTick;
    logic [SenseW-1:0] senseCount;
    logic [StepW-1:0]  stepCount;

    // Two-flop synchronizer, then a rising edge detector
    always_ff @(posedge Clock50)
    begin
        if (reset)
        begin
            vSyncMeta <= 1'b0;
            vSyncSync <= 1'b0;
            vSyncLast <= 1'b0;
            frameTick <= 1'b0;
        end
        else
        begin
            vSyncMeta <= vSync;
            vSyncSync <= vSyncMeta;
            vSyncLast <= vSyncSync;
            frameTick <= vSyncSync & ~vSyncLast;   // One cycle per frame
        end
    end

    always_ff @(posedge Clock50)
    begin
        if (reset)
            senseCount <= '0;
        else if (senseTick)
            senseCount <= '0;
        else if (frameTick)
            senseCount <= senseCount + SenseW'(1);
    end

    always_ff @(posedge Clock50)
    begin
        if (reset)
            stepCount <= '0;
        else if (stepTick)
            stepCount <= '0;
        else if (frameTick)
            stepCount <= stepCount + StepW'(1);
    end

    // Ticks ride on the frame that completes each count
    assign senseTick = frameTick && (senseCount == SenseW'(FramesPerSense - 1));
    assign stepTick  = frameTick && (stepCount == StepW'(FramesPerStep - 1));

endmodule

/* hdl/gridMap.sv */
`timescale 1ns/1ps

module gridMap
    import robotPkg::*;
(
    input  logic    Clock50,
    input  logic    reset,
    input  rowT     cellRow,
    input  colT     cellCol,
    input  logic    cellWrite,
    input  cellT    cellValue,
    output cellT    cellData,
    input  rowT     robotRow,
    input  colT     robotCol,
    input  headingT robotHeading,
    input  logic    clearFront,
    output cellT    hereCell,
    output cellT    frontCell,
    output cellT    leftCell,
    output logic    frontAtEdge,
    output logic    leftAtEdge
);

    cellT    grid [GridRows][GridCols];
    logic    cellInRange;
    headingT leftHeading;
    rowT     frontRow;
    colT     frontCol;
    rowT     leftRow;
    colT     leftCol;

    assign cellInRange = (cellRow < rowT'(GridRows)) && (cellCol < colT'(GridCols));

    // Front neighbor comes straight from the heading
    assign frontRow    = nextRow(robotRow, robotHeading);
    assign frontCol    = nextCol(robotCol, robotHeading);
    assign frontAtEdge = offGrid(robotRow, robotCol, robotHeading);

    // Left neighbor is what lies ahead after a left turn
    assign leftHeading = turnLeft(robotHeading);
    assign leftRow     = nextRow(robotRow, leftHeading);
    assign leftCol     = nextCol(robotCol, leftHeading);
    assign leftAtEdge  = offGrid(robotRow, robotCol, leftHeading);

    always_ff @(posedge Clock50)
    begin
        if (reset)
        begin
            for (int r = 0; r < GridRows; r++)
            begin
                for (int c = 0; c < GridCols; c++)
                begin
                    grid[r][c] <= free;
                end
            end
        end
        else if (clearFront && !frontAtEdge)
        begin
            grid[frontRow][frontCol] <= free;   // Debris worn away
        end
        else if (cellWrite && cellInRange)
        begin
            grid[cellRow][cellCol] <= cellValue;
        end
    end

    assign cellData = cellInRange ? grid[cellRow][cellCol] : free;

    assign hereCell = grid[robotRow][robotCol];

    // Off-grid neighbors read as free, the edge flags carry the rest
    assign frontCell = frontAtEdge ? free : grid[frontRow][frontCol];
    assign leftCell  = leftAtEdge ? free : grid[leftRow][leftCol];

endmodule

/* hdl/sensorUnit.sv */
`timescale 1ns/1ps

module sensorUnit
    import robotPkg::*;
(
    input  logic Clock50,
    input  logic reset,
    input  logic senseTick,
    input  cellT hereCell,
    input  cellT frontCell,
    input  cellT leftCell,
    input  logic frontAtEdge,
    input  logic leftAtEdge,
    output logic head,
    output logic left,
    output logic under,
    output logic barrier
);

    always_ff @(posedge Clock50)
    begin
        if (reset)
        begin
            head    <= 1'b0;
            left    <= 1'b0;
            under   <= 1'b0;
            barrier <= 1'b0;
        end
        else if (senseTick)
        begin
            // Grid border counts as a wall
            head  <= frontAtEdge || (frontCell == wall);
            left  <= leftAtEdge || (leftCell == wall);
            under <= (hereCell == blackCell);
            barrier <= !frontAtEdge && (debrisLife(frontCell) != 4'd0);
        end
    end

endmodule

/* hdl/robotMotion.sv */
`timescale 1ns/1ps

module robotMotion
    import robotPkg::*;
#(
    parameter int      StartRow     = 0,
    parameter int      StartCol     = 0,
    parameter headingT StartHeading = north
)
(
    input  logic    Clock50,
    input  logic    reset,
    input  logic    stepTick,
    input  logic    senseTick,
    input  logic    advance,
    input  logic    turn,
    input  logic    remove,
    input  logic    barrier,
    input  cellT    frontCell,
    input  logic    frontAtEdge,
    output rowT     robotRow,
    output colT     robotCol,
    output headingT robotHeading,
    output logic    clearFront,
    output logic    anomaly
);

    lifeT life;
    logic stepLive;
    logic removing;
    logic stepBlocked;

    assign stepLive    = stepTick && !anomaly;   // Frozen once anomaly is up
    assign removing    = (life != 4'd0) && remove;
    assign stepBlocked = frontAtEdge || isBlocking(frontCell);

    // Debris life counter
    always_ff @(posedge Clock50)
    begin
        if (reset)
        begin
            life <= 4'd0;
        end
        else if (stepLive && removing)
        begin
            life <= life - 4'd1;
        end
        else if (senseTick && barrier && (life == 4'd0))
        begin
            life <= debrisLife(frontCell);   // Arm for the debris ahead
        end
    end

    // Last remove step frees the cell ahead
    always_ff @(posedge Clock50)
    begin
        if (reset)
            clearFront <= 1'b0;
        else
            clearFront <= stepLive && removing && (life == 4'd1);
    end

    // Pose update, one action per step
    always_ff @(posedge Clock50)
    begin
        if (reset)
        begin
            robotRow     <= rowT'(StartRow);
            robotCol     <= colT'(StartCol);
            robotHeading <= StartHeading;
            anomaly      <= 1'b0;
        end
        else if (stepLive && !removing)
        begin
            if (advance)
            begin
                if (stepBlocked)
                begin
                    anomaly <= 1'b1;     // Sticky until reset
                end
                else
                begin
                    robotRow <= nextRow(robotRow, robotHeading);
                    robotCol <= nextCol(robotCol, robotHeading);
                end
            end
            else if (turn)
            begin
                robotHeading <= turnLeft(robotHeading);
            end
        end
    end

endmodule

/* hdl/robotController.sv */
`timescale 1ns/1ps

module robotController
    import robotPkg::*;
#(
    parameter int      FramesPerSense = 5,
    parameter int      FramesPerStep  = 9,
    parameter int      StartRow       = 4,
    parameter int      StartCol       = 9,
    parameter headingT StartHeading   = north
)
(
    input  logic    Clock50,
    input  logic    reset,
    input  logic    vSync,
    input  logic    advance,
    input  logic    turn,
    input  logic    remove,
    input  rowT     cellRow,
    input  colT     cellCol,
    input  logic    cellWrite,
    input  cellT    cellValue,
    output cellT    cellData,
    output logic    head,
    output logic    left,
    output logic    under,
    output logic    barrier,
    output logic    anomaly,
    output rowT     robotRow,
    output colT     robotCol,
    output headingT robotHeading
);

    logic senseTick;
    logic stepTick;
    logic clearFront;
    logic frontAtEdge;
    logic leftAtEdge;
    cellT hereCell;
    cellT frontCell;
    cellT leftCell;

    frameTimer
    #(
        .FramesPerSense (FramesPerSense),
        .FramesPerStep  (FramesPerStep)
    )
    i_frameTimer
    (
        .Clock50   (Clock50),
        .reset     (reset),
        .vSync     (vSync),
        .senseTick (senseTick),
        .stepTick  (stepTick)
    );

    gridMap i_gridMap
    (
        .Clock50      (Clock50),
        .reset        (reset),
        .cellRow      (cellRow),
        .cellCol      (cellCol),
        .cellWrite    (cellWrite),
        .cellValue    (cellValue),
        .cellData     (cellData),
        .robotRow     (robotRow),
        .robotCol     (robotCol),
        .robotHeading (robotHeading),
        .clearFront   (clearFront),
        .hereCell     (hereCell),
        .frontCell    (frontCell),
        .leftCell     (leftCell),
        .frontAtEdge  (frontAtEdge),
        .leftAtEdge   (leftAtEdge)
    );

    sensorUnit i_sensorUnit
    (
        .Clock50     (Clock50),
        .reset       (reset),
        .senseTick   (senseTick),
        .hereCell    (hereCell),
        .frontCell   (frontCell),
        .leftCell    (leftCell),
        .frontAtEdge (frontAtEdge),
        .leftAtEdge  (leftAtEdge),
        .head        (head),
        .left        (left),
        .under       (under),
        .barrier     (barrier)
    );

    robotMotion
    #(
        .StartRow     (StartRow),
        .StartCol     (StartCol),
        .StartHeading (StartHeading)
    )
    i_robotMotion
    (
        .Clock50      (Clock50),
        .reset        (reset),
        .stepTick     (stepTick),
        .senseTick    (senseTick),
        .advance      (advance),
        .turn         (turn),
        .remove       (remove),
        .barrier      (barrier),
        .frontCell    (frontCell),
        .frontAtEdge  (frontAtEdge),
        .robotRow     (robotRow),
        .robotCol     (robotCol),
        .robotHeading (robotHeading),
        .clearFront   (clearFront),
        .anomaly      (anomaly)
    );

endmodule

/* dv/robotController_properties.sv */
`timescale 1ns/1ps

module robotController_properties
    import robotPkg::*;
(
    input logic    Clock50,
    input logic    reset,
    input logic    senseTick,
    input logic    stepTick,
    input logic    anomaly,
    input rowT     robotRow,
    input colT     robotCol,
    input headingT robotHeading
);

    int failCount = 0;

    // Ticks are single-cycle pulses
    senseTickPulse: assert property (@(posedge Clock50) disable iff (reset)
        senseTick |=> !senseTick)
    else
    begin
        $error("senseTick high on two cycles in a row");
        failCount++;
    end

    stepTickPulse: assert property (@(posedge Clock50) disable iff (reset)
        stepTick |=> !stepTick)
    else
    begin
        $error("stepTick high on two cycles in a row");
        failCount++;
    end

    anomalySticky: assert property (@(posedge Clock50) disable iff (reset)
        anomaly |=> anomaly)
    else
    begin
        $error("anomaly dropped without a reset");
        failCount++;
    end

    // Robot frozen while anomaly is up
    poseFrozen: assert property (@(posedge Clock50) disable iff (reset)
        anomaly |=> $stable(robotRow) && $stable(robotCol) && $stable(robotHeading))
    else
    begin
        $error("robot pose changed while anomaly was set");
        failCount++;
    end

endmodule

bind robotController robotController_properties i_properties
(
    .Clock50      (Clock50),
    .reset        (reset),
    .senseTick    (senseTick),
    .stepTick     (stepTick),
    .anomaly      (anomaly),
    .robotRow     (robotRow),
    .robotCol     (robotCol),
    .robotHeading (robotHeading)
);

/* dv/robotControllerTb.sv */
`timescale 1ns/1ps

module robotControllerTb
    import robotPkg::*;
();

    localparam int FramesPerSense = 5;
    localparam int FramesPerStep  = 9;
    localparam int ResetCycles    = 8;
    localparam int VSyncHigh      = 4;      // Also the limit for the frame tick to show up
    localparam int VSyncLow       = 12;
    localparam int LineLimit      = 400;

    logic    Clock50;
    logic    reset;
    logic    vSync;
    logic    advance;
    logic    turn;
    logic    remove;
    rowT     cellRow;
    colT     cellCol;
    logic    cellWrite;
    cellT    cellValue;
    cellT    cellData;
    logic    head;
    logic    left;
    logic    under;
    logic    barrier;
    logic    anomaly;
    rowT     robotRow;
    colT     robotCol;
    headingT robotHeading;

    int testErrors;
    int totalErrors;
    int testsRun;
    int testsFailed;
    bit aborted;

    robotController
    #(
        .FramesPerSense (FramesPerSense),
        .FramesPerStep  (FramesPerStep)
    )
    i_robotController (.*);

    initial
    begin
        Clock50 = 1'b0;
        forever #5 Clock50 = ~Clock50;
    end

    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            testErrors++;
        end
    endtask

    task automatic applyReset();
        @(posedge Clock50);
        reset <= 1'b1;
        for (int cycle = 0; cycle < ResetCycles; cycle++)
            @(posedge Clock50);
        reset <= 1'b0;
    endtask

    // One vSync pulse, then the low stretch of the frame
    task automatic runFrame();
        bit tickSeen;
        tickSeen = 1'b0;
        @(posedge Clock50);
        vSync <= 1'b1;
        for (int cycle = 0; cycle < VSyncHigh; cycle++)
        begin
            @(negedge Clock50);
            tickSeen = tickSeen | i_robotController.i_frameTimer.frameTick;
        end
        if (!tickSeen)
        begin
            $display("Timeout: no frame tick within %0d cycles of the vSync rise", VSyncHigh);
            aborted = 1'b1;
        end
        @(posedge Clock50);
        vSync <= 1'b0;
        for (int cycle = 1; cycle < VSyncLow; cycle++)
            @(posedge Clock50);
    endtask

    task automatic writeCell(input int row, input int col, input int value);
        @(posedge Clock50);
        cellRow   <= rowT'(row);
        cellCol   <= colT'(col);
        cellValue <= cellT'(value);
        cellWrite <= 1'b1;
        @(posedge Clock50);
        cellWrite <= 1'b0;
    endtask

    task automatic readCell(input int row, input int col, input int expected);
        @(posedge Clock50);
        cellRow <= rowT'(row);
        cellCol <= colT'(col);
        @(negedge Clock50);         // Read port is combinational
        checkValue($sformatf("cellData[%0d][%0d]", row, col), int'(cellData), expected);
    endtask

    task automatic finishTest(input int number);
        testsRun++;
        if (testErrors == 0)
            $display("Test %0d passed", number);
        else
        begin
            $display("Test %0d failed with %0d mismatches", number, testErrors);
            testsFailed++;
        end
        totalErrors += testErrors;
        testErrors = 0;
    endtask

    initial
    begin
        int    fd;
        int    lineCount;
        int    fld [8];
        byte   op;
        string line;
        reset = 1'b1;
        vSync = 1'b0;
        advance = 1'b0;
        turn = 1'b0;
        remove = 1'b0;
        cellRow = '0;
        cellCol = '0;
        cellWrite = 1'b0;
        cellValue = free;
        testErrors = 0;
        totalErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        aborted = 1'b0;
        lineCount = 0;
        applyReset();
        fd = $fopen("dv/robot_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test data file dv/robot_testdata.txt");
            aborted = 1'b1;
        end
        while (!aborted && lineCount < LineLimit && !$feof(fd))
        begin
            line = "";
            lineCount++;
            if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n")
            begin
                op = line[0];
                foreach (fld[i])
                    fld[i] = 0;
                void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d %d %d",
                              fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]));
                case (op)
                    "W": writeCell(fld[0], fld[1], fld[2]);
                    "C": readCell(fld[0], fld[1], fld[2]);
                    "R": applyReset();
                    "T": finishTest(fld[0]);
                    "F":
                    begin
                        @(posedge Clock50);
                        advance <= (fld[1] != 0);
                        turn    <= (fld[2] != 0);
                        remove  <= (fld[3] != 0);
                        for (int frame = 0; frame < fld[0] && !aborted; frame++)
                            runFrame();
                    end
                    "P":
                    begin
                        @(negedge Clock50);
                        checkValue("robotRow", int'(robotRow), fld[0]);
                        checkValue("robotCol", int'(robotCol), fld[1]);
                        checkValue("robotHeading", int'(robotHeading), fld[2]);
                        checkValue("head", int'(head), fld[3]);
                        checkValue("left", int'(left), fld[4]);
                        checkValue("under", int'(under), fld[5]);
                        checkValue("barrier", int'(barrier), fld[6]);
                        checkValue("anomaly", int'(anomaly), fld[7]);
                    end
                    default:
                    begin
                        $display("Unknown command in the test data: %s", line);
                        aborted = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("Tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 testsRun, testsFailed, totalErrors + testErrors,
                 i_robotController.i_properties.failCount);
        if (!aborted && totalErrors == 0 && testErrors == 0 && testsRun > 0
            && i_robotController.i_properties.failCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* dv/robot_testdata.txt */
# W row col value | C row col expected value | F frames advance turn remove
# P row col heading head left under barrier anomaly | R reset | T test number
P 4 9 0 0 0 0 0 0
C 0 0 0
C 9 19 0
C 4 9 0
T 1
W 3 9 1
W 5 9 1
W 4 9 2
C 3 9 1
C 4 9 2
F 5 0 0 0
P 4 9 0 1 0 1 0 0
F 5 0 1 0
P 4 9 1 0 1 1 0 0
F 10 0 1 0
P 4 9 2 1 0 1 0 0
F 10 0 1 0
P 4 9 3 0 1 1 0 0
T 2
F 10 1 0 0
P 4 10 3 0 0 0 0 0
F 5 0 1 0
P 4 10 0 0 0 0 0 0
T 3
W 3 10 3
F 5 0 0 1
P 4 10 0 0 0 0 1 0
F 30 0 0 1
P 4 10 0 0 0 0 1 0
C 3 10 3
F 5 0 0 1
P 4 10 0 0 0 0 0 0
C 3 10 0
W 3 10 5
F 85 0 0 1
P 4 10 0 0 0 0 1 0
C 3 10 5
F 5 0 0 1
P 4 10 0 0 0 0 0 0
C 3 10 0
T 4
W 3 10 1
F 5 1 0 0
P 4 10 0 1 0 0 0 1
F 18 1 1 0
P 4 10 0 1 0 0 0 1
R
P 4 9 0 0 0 0 0 0
C 3 10 0
F 45 1 0 0
P 0 9 0 1 0 0 0 1
T 5

/* sim.f */
hdl/robotPkg.sv
hdl/frameTimer.sv
hdl/gridMap.sv
hdl/sensorUnit.sv
hdl/robotMotion.sv
hdl/robotController.sv
dv/robotController_properties.sv
dv/robotControllerTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module robotControllerTb -o robotSim
./obj_dir/robotSim | tee sim.log
if grep -q "SIMULATION PASSED" sim.log
then
    echo "Run passed"
else
    echo "Run failed"
    exit 1
fi
